// File: design/bus_pkg.sv
// Wishbone classic bus package
// request/response bundles and the decoded access kind
package bus_pkg;

    localparam int unsigned WB_AW = 32;          // byte address width
    localparam int unsigned WB_DW = 32;          // data width
    localparam int unsigned WB_SW = WB_DW / 8;   // one select bit per byte lane

    // master to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_SW-1:0] sel;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;   // read data, valid with ack
    } wb_rsp_t;

    // kind of access, taken from we
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

endpackage : bus_pkg

// File: design/dram_pkg.sv
// DRAM model package
// line geometry, bank and row mapping, timing and line channel types
package dram_pkg;

    localparam int unsigned WORD_BYTES     = 4;
    localparam int unsigned WORD_W         = 8 * WORD_BYTES;
    localparam int unsigned LINE_BYTES     = 16;
    localparam int unsigned WORDS_PER_LINE = LINE_BYTES / WORD_BYTES;
    localparam int unsigned LINE_W         = 8 * LINE_BYTES;
    localparam int unsigned LINE_ADDR_W    = 8;   // 256 lines, 4 KB

    localparam int unsigned BYTE_OFF_W = $clog2(WORD_BYTES);
    localparam int unsigned WORD_IDX_W = $clog2(WORDS_PER_LINE);
    localparam int unsigned LINE_OFF_W = $clog2(LINE_BYTES);

    // banks interleave on the low line bits
    localparam int unsigned NUM_BANKS = 4;
    localparam int unsigned BANK_W    = $clog2(NUM_BANKS);
    localparam int unsigned ROW_LINES = 16;
    localparam int unsigned ROW_W     = LINE_ADDR_W - $clog2(ROW_LINES);

    // read latency in cycles
    localparam int unsigned T_HIT  = 4;
    localparam int unsigned T_MISS = 10;
    localparam int unsigned LAT_W  = $clog2(T_MISS + 1);

    localparam int unsigned RD_QUEUE_DEPTH = 4;
    localparam int unsigned QPTR_W         = $clog2(RD_QUEUE_DEPTH);

    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;
    typedef logic [LINE_ADDR_W-1:0]                line_addr_t;

    typedef struct packed {
        logic       we;
        line_addr_t addr;
        line_t      wdata;   // ignored on reads
    } dram_req_t;

    // reads only, writes give no response
    typedef struct packed {
        line_t rdata;
    } dram_rsp_t;

    // line_ctrl sequencing
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_REQ,
        ST_RD_WAIT,
        ST_WR_REQ,
        ST_ACK
    } dram_state_e;

    function automatic logic [BANK_W-1:0] line_bank(line_addr_t addr);
        return addr[BANK_W-1:0];
    endfunction

    function automatic logic [ROW_W-1:0] line_row(line_addr_t addr);
        return addr[LINE_ADDR_W-1 -: ROW_W];
    endfunction

endpackage : dram_pkg

// File: design/word_merge.sv
// Word merge datapath
// picks the addressed word out of a line and merges a byte-masked word back in
`timescale 1ns/1ps

module word_merge import dram_pkg::*; (
    input  line_t                 line_i,
    input  logic [WORD_IDX_W-1:0] word_idx_i,
    input  logic [WORD_BYTES-1:0] sel_i,
    input  logic [WORD_W-1:0]     wdata_i,
    output line_t                 line_o,
    output logic [WORD_W-1:0]     rdata_o
);

    logic [LINE_W/8-1:0][7:0]     line_bytes;
    logic [WORD_BYTES-1:0][7:0]   wdata_bytes;

    assign rdata_o     = line_i[word_idx_i];
    assign wdata_bytes = wdata_i;

    // byte lanes little endian within the line
    always_comb begin
        line_bytes = line_i;
        for (int b = 0; b < LINE_W / 8; b++) begin
            if (b / WORD_BYTES == word_idx_i && sel_i[b % WORD_BYTES]) begin
                line_bytes[b] = wdata_bytes[b % WORD_BYTES];
            end
        end
    end

    assign line_o = line_bytes;

endmodule : word_merge

// File: design/sim_dram.sv
// Behavioral banked DRAM model
// open-row timing per bank, in-order read responses over valid/ready channels
`timescale 1ns/1ps

module sim_dram import dram_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // request channel
    input  dram_req_t req_i,
    input  logic      req_valid_i,
    output logic      req_ready_o,
    // response channel, read data only
    output dram_rsp_t rsp_o,
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i
);

    // storage, zero at time zero
    line_t mem_q [2**LINE_ADDR_W] = '{default: '0};

    // open row per bank
    logic [NUM_BANKS-1:0] row_open_q;
    logic [ROW_W-1:0]     open_row_q [NUM_BANKS];

    // pending reads, circular
    line_t             rd_data_q [RD_QUEUE_DEPTH];
    logic [LAT_W-1:0]  rd_cnt_q  [RD_QUEUE_DEPTH];
    logic [QPTR_W-1:0] rd_head_q;
    logic [QPTR_W-1:0] rd_tail_q;
    logic [QPTR_W:0]   rd_count_q;

    logic              accept;
    logic              rd_push;
    logic              rd_pop;
    logic              row_hit;
    logic [BANK_W-1:0] req_bank;
    logic [ROW_W-1:0]  req_row;
    logic [LAT_W-1:0]  rd_lat;

    assign req_ready_o = rd_count_q < RD_QUEUE_DEPTH;
    assign accept      = req_valid_i && req_ready_o;
    assign rd_push     = accept && !req_i.we;
    assign rd_pop      = rsp_valid_o && rsp_ready_i;

    assign req_bank = line_bank(req_i.addr);
    assign req_row  = line_row(req_i.addr);
    assign row_hit  = row_open_q[req_bank] && (open_row_q[req_bank] == req_row);
    assign rd_lat   = row_hit ? LAT_W'(T_HIT) : LAT_W'(T_MISS);

    // head goes out once its countdown has run down
    assign rsp_valid_o = (rd_count_q != '0) && (rd_cnt_q[rd_head_q] == '0);
    assign rsp_o.rdata = rd_data_q[rd_head_q];

    always_ff @(posedge clk_i) begin
        if (accept && req_i.we) begin
            mem_q[req_i.addr] <= req_i.wdata;
        end
    end

    // row state follows every access, read or write
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            row_open_q <= '0;
        end else if (accept) begin
            row_open_q[req_bank] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            open_row_q[req_bank] <= req_row;
        end
    end

    // line is captured at acceptance, so a later write cannot change it
    always_ff @(posedge clk_i) begin
        if (rd_push) begin
            rd_data_q[rd_tail_q] <= mem_q[req_i.addr];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_head_q  <= '0;
            rd_tail_q  <= '0;
            rd_count_q <= '0;
        end else begin
            if (rd_push) begin
                rd_tail_q <= rd_tail_q + 1'b1;
            end
            if (rd_pop) begin
                rd_head_q <= rd_head_q + 1'b1;
            end
            rd_count_q <= rd_count_q + rd_push - rd_pop;
        end
    end

    // every entry counts down on its own, order is kept by the head pointer
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 0; i < RD_QUEUE_DEPTH; i++) begin
                rd_cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < RD_QUEUE_DEPTH; i++) begin
                if (rd_push && rd_tail_q == QPTR_W'(i)) begin
                    rd_cnt_q[i] <= rd_lat;
                end else if (rd_cnt_q[i] != '0) begin
                    rd_cnt_q[i] <= rd_cnt_q[i] - 1'b1;
                end
            end
        end
    end

    // requester must hold a stalled request
    a_req_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i)
    ) else $error("request changed while stalled");

    a_rsp_stable : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o)
    ) else $error("response changed under back-pressure");

    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rd_count_q <= RD_QUEUE_DEPTH
    ) else $error("read queue overflow");

endmodule : sim_dram

// File: design/line_ctrl.sv
// Line access controller
// turns one Wishbone word access into a line read, and for writes a line write
`timescale 1ns/1ps

module line_ctrl import bus_pkg::*; import dram_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // Wishbone slave side
    input  wb_req_t               wb_i,
    output wb_rsp_t               wb_o,
    // DRAM request and response
    output dram_req_t             dram_req_o,
    output logic                  dram_req_valid_o,
    input  logic                  dram_req_ready_i,
    input  dram_rsp_t             dram_rsp_i,
    input  logic                  dram_rsp_valid_i,
    output logic                  dram_rsp_ready_o,
    // merge datapath
    output line_t                 merge_line_o,
    output logic [WORD_IDX_W-1:0] merge_idx_o,
    output logic [WORD_BYTES-1:0] merge_sel_o,
    output logic [WORD_W-1:0]     merge_wdata_o,
    input  line_t                 merge_line_i,
    input  logic [WORD_W-1:0]     merge_rdata_i
);

    dram_state_e state_q;
    dram_state_e state_d;
    bus_op_e     op_q;
    bus_op_e     op_d;
    line_t       line_q;   // line fetched for the current access

    logic access;
    logic req_fire;
    logic rsp_fire;

    assign access   = wb_i.cyc && wb_i.stb;
    assign req_fire = dram_req_valid_o && dram_req_ready_i;
    assign rsp_fire = dram_rsp_valid_i && dram_rsp_ready_o;

    always_comb begin
        state_d = state_q;
        op_d    = op_q;
        unique case (state_q)
            ST_IDLE: begin
                if (access) begin
                    op_d    = wb_i.we ? OP_WRITE : OP_READ;
                    // line read goes out in the first cycle if the DRAM takes it
                    state_d = req_fire ? ST_RD_WAIT : ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                if (req_fire) begin
                    state_d = ST_RD_WAIT;
                end
            end
            ST_RD_WAIT: begin
                if (rsp_fire) begin
                    state_d = (op_q == OP_WRITE) ? ST_WR_REQ : ST_ACK;
                end
            end
            ST_WR_REQ: begin
                if (req_fire) begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK: begin
                state_d = ST_IDLE;   // single-cycle ack
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            op_q    <= OP_READ;
        end else begin
            state_q <= state_d;
            op_q    <= op_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_fire) begin
            line_q <= dram_rsp_i.rdata;
        end
    end

    // master holds adr/sel/dat until ack, so these stay stable while valid
    assign dram_req_valid_o = (state_q == ST_IDLE && access)
                            || state_q == ST_RD_REQ
                            || state_q == ST_WR_REQ;
    assign dram_req_o.we    = (state_q == ST_WR_REQ);
    assign dram_req_o.addr  = wb_i.adr[LINE_OFF_W +: LINE_ADDR_W];   // high bits alias
    assign dram_req_o.wdata = merge_line_i;
    assign dram_rsp_ready_o = (state_q == ST_RD_WAIT);

    assign merge_line_o  = line_q;
    assign merge_idx_o   = wb_i.adr[BYTE_OFF_W +: WORD_IDX_W];
    assign merge_sel_o   = wb_i.sel;
    assign merge_wdata_o = wb_i.dat;

    assign wb_o.ack = (state_q == ST_ACK);
    assign wb_o.dat = merge_rdata_i;

    a_ack_pulse : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_o.ack |=> !wb_o.ack
    ) else $error("ack held for more than one cycle");

    // master keeps cyc and stb up until it sees ack
    a_ack_in_cycle : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        wb_o.ack |-> wb_i.cyc && wb_i.stb
    ) else $error("ack outside of an active bus cycle");

endmodule : line_ctrl

// File: design/mem_subsys_top.sv
// Simulation memory subsystem
// Wishbone classic slave in front of a line controller and a banked DRAM model
`timescale 1ns/1ps

module mem_subsys_top import bus_pkg::*; import dram_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  wb_req_t wb_i,
    output wb_rsp_t wb_o
);

    dram_req_t             dram_req;
    logic                  dram_req_valid;
    logic                  dram_req_ready;
    dram_rsp_t             dram_rsp;
    logic                  dram_rsp_valid;
    logic                  dram_rsp_ready;

    line_t                 merge_line_in;    // line_ctrl -> word_merge
    line_t                 merge_line_out;   // word_merge -> line_ctrl
    logic [WORD_IDX_W-1:0] merge_idx;
    logic [WORD_BYTES-1:0] merge_sel;
    logic [WORD_W-1:0]     merge_wdata;
    logic [WORD_W-1:0]     merge_rdata;

    line_ctrl line_ctrl_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .wb_i             (wb_i),
        .wb_o             (wb_o),
        .dram_req_o       (dram_req),
        .dram_req_valid_o (dram_req_valid),
        .dram_req_ready_i (dram_req_ready),
        .dram_rsp_i       (dram_rsp),
        .dram_rsp_valid_i (dram_rsp_valid),
        .dram_rsp_ready_o (dram_rsp_ready),
        .merge_line_o     (merge_line_in),
        .merge_idx_o      (merge_idx),
        .merge_sel_o      (merge_sel),
        .merge_wdata_o    (merge_wdata),
        .merge_line_i     (merge_line_out),
        .merge_rdata_i    (merge_rdata)
    );

    word_merge word_merge_i (
        .line_i     (merge_line_in),
        .word_idx_i (merge_idx),
        .sel_i      (merge_sel),
        .wdata_i    (merge_wdata),
        .line_o     (merge_line_out),
        .rdata_o    (merge_rdata)
    );

    sim_dram sim_dram_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_i       (dram_req),
        .req_valid_i (dram_req_valid),
        .req_ready_o (dram_req_ready),
        .rsp_o       (dram_rsp),
        .rsp_valid_o (dram_rsp_valid),
        .rsp_ready_i (dram_rsp_ready)
    );

endmodule : mem_subsys_top

// File: tb/tb_mem_subsys.sv
// Testbench for the simulation memory subsystem
// Wishbone driver, shadow memory reference and a read data checker
`timescale 1ns/1ps

module tb_mem_subsys import bus_pkg::*; import dram_pkg::*; ();

    localparam int unsigned ACK_TIMEOUT  = 100;
    localparam int unsigned NUM_RANDOM   = 300;
    localparam int unsigned SHADOW_WORDS = 1024;   // 4 KB decoded, upper bits alias

    logic    clk;
    logic    rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    logic [WB_DW-1:0] shadow [SHADOW_WORDS];
    int               errors;
    int               reads_issued;
    int               reads_checked;

    mem_subsys_top mem_subsys_top_i (
        .clk_i  (clk),
        .rst_ni (rst_n),
        .wb_i   (wb_req),
        .wb_o   (wb_rsp)
    );

    always #20 clk = ~clk;

    // expected word, only address bits 11:2 select it
    function automatic logic [WB_DW-1:0] ref_read(input logic [WB_AW-1:0] adr);
        return shadow[adr[11:2]];
    endfunction

    function automatic void ref_write(input logic [WB_AW-1:0] adr,
                                      input logic [WB_SW-1:0] sel,
                                      input logic [WB_DW-1:0] dat);
        logic [9:0] idx;
        idx = adr[11:2];
        for (int b = 0; b < WB_SW; b++) begin
            if (sel[b]) begin
                shadow[idx][8*b +: 8] = dat[8*b +: 8];
            end
        end
    endfunction

    task automatic check_word(input string name, input logic [WB_DW-1:0] got,
                              input logic [WB_DW-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_op_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    // one classic cycle, starts and ends 2 ns after a rising edge
    task automatic wb_cycle(input bus_op_e op, input logic [WB_AW-1:0] adr,
                            input logic [WB_SW-1:0] sel, input logic [WB_DW-1:0] dat,
                            output logic [WB_DW-1:0] rdata, output int cycles);
        logic got_ack;
        got_ack    = 1'b0;
        cycles     = 0;
        rdata      = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = (op == OP_WRITE);
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.dat = dat;
        while (!got_ack && cycles < ACK_TIMEOUT) begin
            @(negedge clk);   // outputs settled mid-cycle
            cycles++;
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
                rdata   = wb_rsp.dat;
            end
        end
        if (!got_ack) begin
            errors++;
            $display("no ack within %0d cycles for %s at address %h",
                     ACK_TIMEOUT, op.name(), adr);
        end else if (op == OP_WRITE) begin
            ref_write(adr, sel, dat);
        end
        @(posedge clk);
        #2;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_SW-1:0] sel,
                            input logic [WB_DW-1:0] dat);
        logic [WB_DW-1:0] unused_dat;
        int               cycles;
        wb_cycle(OP_WRITE, adr, sel, dat, unused_dat, cycles);
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdata,
                           output int cycles);
        reads_issued++;
        wb_cycle(OP_READ, adr, '0, '0, rdata, cycles);
    endtask

    // every acked read is checked against the shadow memory
    always @(negedge clk) begin
        if (rst_n && wb_rsp.ack && bus_op_e'(wb_req.we) == OP_READ) begin
            check_word("wb_o.dat", wb_rsp.dat, ref_read(wb_req.adr));
            reads_checked++;
        end
    end

    initial begin
        logic [WB_DW-1:0] rdata;
        logic [WB_AW-1:0] adr;
        logic [WB_SW-1:0] sel_list [10];
        int               cycles;
        int               t_hit;
        int               t_miss;
        int               t_hit2;
        clk           = 1'b0;
        rst_n         = 1'b0;
        wb_req        = '0;
        errors        = 0;
        reads_issued  = 0;
        reads_checked = 0;
        for (int i = 0; i < SHADOW_WORDS; i++) begin
            shadow[i] = '0;   // DRAM storage starts at zero
        end
        void'($urandom(32'h9267));
        sel_list = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h5, 4'h6, 4'h9, 4'hA, 4'hC};
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // idle bus after reset
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            if (wb_rsp.ack) begin
                errors++;
                $display("ack raised with no bus cycle after reset");
            end
        end
        @(posedge clk);
        #2;

        // full word write, neighbours in the line must survive
        wb_write(32'h0000_0100, 4'hF, 32'h1111_1111);
        wb_write(32'h0000_0108, 4'hF, 32'h3333_3333);
        wb_write(32'h0000_010C, 4'hF, 32'h4444_4444);
        wb_write(32'h0000_0104, 4'hF, 32'hCAFE_F00D);
        wb_read(32'h0000_0104, rdata, cycles);
        check_word("wb_o.dat", rdata, 32'hCAFE_F00D);
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            wb_read(32'h0000_0100 + 4 * w, rdata, cycles);
        end

        // single and paired byte selects over a known base word
        foreach (sel_list[k]) begin
            adr = 32'h0000_0200 + 4 * k;
            wb_write(adr, 4'hF, $urandom);
            wb_write(adr, sel_list[k], $urandom);
            wb_read(adr, rdata, cycles);
        end

        // random traffic, high address bits random too
        for (int n = 0; n < NUM_RANDOM; n++) begin
            adr      = $urandom;
            adr[1:0] = 2'b00;
            if ($urandom_range(1, 0) == 1) begin
                wb_write(adr, 4'($urandom), $urandom);
            end else begin
                wb_read(adr, rdata, cycles);
            end
        end

        // bank 0: lines 0x00 and 0x04 share row 0, lines 0x10 and 0x14 are row 1
        wb_read(32'h0000_0000, rdata, cycles);   // opens row 0
        wb_read(32'h0000_0040, rdata, t_hit);
        wb_read(32'h0000_0100, rdata, t_miss);
        wb_read(32'h0000_0140, rdata, t_hit2);
        check_op_latency("read miss minus hit cycles", t_miss - t_hit,
                         int'(T_MISS) - int'(T_HIT));
        check_op_latency("read hit cycles after row change", t_hit2, t_hit);

        if (reads_checked != reads_issued) begin
            errors++;
            $display("read checker saw %0d of %0d reads", reads_checked, reads_issued);
        end
        $display("errors: %0d, reads checked: %0d", errors, reads_checked);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_mem_subsys

// File: vlog.f
design/bus_pkg.sv
design/dram_pkg.sv
design/word_merge.sv
design/sim_dram.sv
design/line_ctrl.sv
design/mem_subsys_top.sv
tb/tb_mem_subsys.sv
